//--- filelist.f
+incdir+testbench
hw/vex_pkg.sv
hw/vec_bank.sv
hw/vec_mask_unit.sv
hw/vec_lane_alu.sv
hw/vec_mask_set_layer.sv
hw/vec_reduction_unit.sv
hw/vex_datapath.sv
testbench/tb_vex_datapath.sv

//--- hw/vec_bank.sv
`timescale 1ns/10ps
`default_nettype none

// one lane's slice of the vector register file
module vec_bank #(
    parameter int NUM_VREGS = 8
) (
    input  logic               CLK,
    input  logic               rst,
    input  vex_pkg::vreg_idx_t raddr1,
    input  vex_pkg::vreg_idx_t raddr2,
    input  vex_pkg::vreg_idx_t raddr3,
    input  logic               wen,
    input  vex_pkg::vreg_idx_t waddr,
    input  vex_pkg::word_t     wdata,
    output vex_pkg::word_t     rdata1,
    output vex_pkg::word_t     rdata2,
    output vex_pkg::word_t     rdata3,
    output vex_pkg::word_t     v0_elem
);

    import vex_pkg::*;

    // index bits actually decoded
    localparam int addr_w = $clog2(NUM_VREGS);

    word_t regs [NUM_VREGS];

    // write port, whole bank cleared on reset
    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < NUM_VREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr[addr_w-1:0]] <= wdata;
        end
    end

    // combinational read ports: vs1, vs2, vd
    assign rdata1 = regs[raddr1[addr_w-1:0]];
    assign rdata2 = regs[raddr2[addr_w-1:0]];
    assign rdata3 = regs[raddr3[addr_w-1:0]];

    // v0 tap for the mask unit
    assign v0_elem = regs[0];

endmodule

`default_nettype wire

//--- hw/vec_lane_alu.sv
`timescale 1ns/10ps
`default_nettype none

// one lane's element-wise unit
module vec_lane_alu (
    input  vex_pkg::vop_t  op,
    input  vex_pkg::word_t opa,
    input  vex_pkg::word_t opb,
    input  vex_pkg::word_t old_vd,
    input  logic           active,
    output vex_pkg::word_t res,
    output logic           cmp
);

    import vex_pkg::*;

    word_t alu_out;

    // compare bit, opa is vs2 and opb is vs1 or scalar
    always_comb begin
        case (op)
            VOP_SEQ: cmp = (opa == opb);
            VOP_SLT: cmp = ($signed(opa) < $signed(opb));
            default: cmp = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            VOP_ADD: begin
                alu_out = opa + opb;
            end
            VOP_SUB: begin
                // vs2 - vs1
                alu_out = opa - opb;
            end
            VOP_AND: begin
                alu_out = opa & opb;
            end
            VOP_OR: begin
                alu_out = opa | opb;
            end
            VOP_XOR: begin
                alu_out = opa ^ opb;
            end
            VOP_MV: begin
                alu_out = opb;
            end
            VOP_SEQ, VOP_SLT: begin
                // packed into vd by the mask set layer, lane value unused
                alu_out = {31'b0, cmp};
            end
            default: begin
                alu_out = opa;
            end
        endcase
    end

    // masked-off lanes keep the old destination element
    assign res = active ? alu_out : old_vd;

endmodule

`default_nettype wire

//--- hw/vec_mask_set_layer.sv
`timescale 1ns/10ps
`default_nettype none

// packs lane compare bits into element 0 of vd
module vec_mask_set_layer (
    input  logic [vex_pkg::num_lanes-1:0] cmp_bits,
    input  logic [vex_pkg::num_lanes-1:0] mask_bits,
    input  vex_pkg::word_t                old_vd0,
    output vex_pkg::word_t                mask_word
);

    import vex_pkg::*;

    always_comb begin
        // bits past the lane count stay zero
        mask_word = '0;
        for (int k = 0; k < num_lanes; k++) begin
            // inactive lanes keep whatever vd held
            mask_word[k] = mask_bits[k] ? cmp_bits[k] : old_vd0[k];
        end
    end

endmodule

`default_nettype wire

//--- hw/vec_mask_unit.sv
`timescale 1ns/10ps
`default_nettype none

// per-lane mask bits from v0 element 0
module vec_mask_unit (
    input  vex_pkg::word_t                v0_elem,
    input  logic                          mask_en,
    output logic [vex_pkg::num_lanes-1:0] mask_bits
);

    import vex_pkg::*;

    // lane k follows bit k of v0, all lanes on when unmasked
    always_comb begin
        for (int k = 0; k < num_lanes; k++) begin
            mask_bits[k] = !mask_en || v0_elem[k];
        end
    end

endmodule

`default_nettype wire

//--- hw/vec_reduction_unit.sv
`timescale 1ns/10ps
`default_nettype none

// sum reduction over the active lanes
module vec_reduction_unit (
    input  vex_pkg::vlanes_t              vsrc,
    input  vex_pkg::word_t                init,
    input  logic [vex_pkg::num_lanes-1:0] mask_bits,
    output vex_pkg::word_t                sum
);

    import vex_pkg::*;

    word_t acc;

    // serial adder chain, wraps at 32 bits
    always_comb begin
        acc = init;
        for (int k = 0; k < num_lanes; k++) begin
            if (mask_bits[k]) begin
                acc = acc + vsrc[k];
            end
        end
    end

    assign sum = acc;

endmodule

`default_nettype wire

//--- hw/vex_datapath.sv
`timescale 1ns/10ps
`default_nettype none

// vector execute stage taking one micro-op per cycle with one cycle latency
module vex_datapath #(
    parameter int NUM_VREGS = 8
) (
    input  logic              CLK,
    input  logic              rst,
    input  vex_pkg::vuop_t    uop,
    output vex_pkg::vresult_t result
);

    import vex_pkg::*;

    // bank read data with one element per lane
    vlanes_t bankdat_src1;
    vlanes_t bankdat_src2;
    vlanes_t bankdat_vd;
    vlanes_t v0_lanes;

    vlanes_t vopb;
    vlanes_t lane_res;

    logic [num_lanes-1:0] mask_bits;
    logic [num_lanes-1:0] cmp_bits;

    word_t vmskset_res;
    word_t vred_res;

    logic is_cmp_op;
    logic is_red_op;

    vresult_t result_next;

    assign is_cmp_op = (uop.op == VOP_SEQ) || (uop.op == VOP_SLT);
    assign is_red_op = (uop.op == VOP_REDSUM);

    // operand B is vs1 or the scalar on every lane
    assign vopb = uop.use_scalar ? {num_lanes{uop.scalar}} : bankdat_src1;

    genvar k;
    generate
        for (k = 0; k < num_lanes; k++) begin : g_lane
            // writeback uses the next result and lands on the edge that loads result
            vec_bank #(
                .NUM_VREGS(NUM_VREGS)
            ) u_bank (
                .CLK    (CLK),
                .rst    (rst),
                .raddr1 (uop.vs1),
                .raddr2 (uop.vs2),
                .raddr3 (uop.vd),
                .wen    (result_next.valid && result_next.lane_mask[k]),
                .waddr  (result_next.vd),
                .wdata  (result_next.data[k]),
                .rdata1 (bankdat_src1[k]),
                .rdata2 (bankdat_src2[k]),
                .rdata3 (bankdat_vd[k]),
                .v0_elem(v0_lanes[k])
            );

            vec_lane_alu u_alu (
                .op    (uop.op),
                .opa   (bankdat_src2[k]),
                .opb   (vopb[k]),
                .old_vd(bankdat_vd[k]),
                .active(mask_bits[k]),
                .res   (lane_res[k]),
                .cmp   (cmp_bits[k])
            );
        end
    endgenerate

    // v0 element 0 lives in lane 0
    vec_mask_unit u_mask_unit (
        .v0_elem  (v0_lanes[0]),
        .mask_en  (uop.mask_en),
        .mask_bits(mask_bits)
    );

    vec_mask_set_layer u_mask_set_layer (
        .cmp_bits (cmp_bits),
        .mask_bits(mask_bits),
        .old_vd0  (bankdat_vd[0]),
        .mask_word(vmskset_res)
    );

    vec_reduction_unit u_reduction_unit (
        .vsrc     (bankdat_src2),
        .init     (bankdat_src1[0]),
        .mask_bits(mask_bits),
        .sum      (vred_res)
    );

    // result select by operation class
    always_comb begin
        result_next.valid     = uop.valid;
        result_next.vd        = uop.vd;
        result_next.data      = lane_res;
        result_next.lane_mask = mask_bits;
        if (is_cmp_op || is_red_op) begin
            // only lane 0 is written while the other lanes echo old vd
            result_next.data      = bankdat_vd;
            result_next.data[0]   = is_cmp_op ? vmskset_res : vred_res;
            result_next.lane_mask = {{(num_lanes-1){1'b0}}, 1'b1};
        end
    end

    // result register with valid cleared on reset
    always_ff @(posedge CLK) begin
        result <= result_next;
        if (rst) begin
            result.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/vex_pkg.sv
`default_nettype none

package vex_pkg;

    // lane count, sizes every per-lane array and struct
    localparam int num_lanes = 4;

    // one 32-bit vector element
    typedef logic [31:0] word_t;

    // architectural register index, banks use only the low bits they need
    typedef logic [4:0] vreg_idx_t;

    typedef enum logic [3:0] {
        VOP_ADD,
        VOP_SUB,
        VOP_AND,
        VOP_OR,
        VOP_XOR,
        VOP_MV,
        VOP_SEQ,
        VOP_SLT,
        VOP_REDSUM
    } vop_t;

    // one element per lane
    typedef word_t [num_lanes-1:0] vlanes_t;

    // micro-op from the decoder
    typedef struct packed {
        logic      valid;
        vop_t      op;
        vreg_idx_t vd;
        vreg_idx_t vs1;
        vreg_idx_t vs2;
        // operand B comes from scalar, broadcast to all lanes
        logic      use_scalar;
        logic      mask_en;
        word_t     scalar;
    } vuop_t;

    // registered result, also the writeback request
    typedef struct packed {
        logic                 valid;
        vreg_idx_t            vd;
        vlanes_t              data;
        logic [num_lanes-1:0] lane_mask;
    } vresult_t;

endpackage

`default_nettype wire

//--- testbench/tb_vex_model.svh
`ifndef TB_VEX_MODEL_SVH
`define TB_VEX_MODEL_SVH

// register copy, matches the default register count of the DUT
localparam int model_vregs = 8;

vlanes_t model_regs [model_vregs];
logic [31:0] lfsr_state;

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// one LFSR step per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
endfunction

function automatic int reg_slot(input vreg_idx_t idx);
    return int'(idx) % model_vregs;
endfunction

// element-wise rule, a is vs2 and b is vs1 or scalar
function automatic word_t elem_op(input vop_t op, input word_t a, input word_t b);
    case (op)
        VOP_ADD: return a + b;
        VOP_SUB: return a - b;
        VOP_AND: return a & b;
        VOP_OR:  return a | b;
        VOP_XOR: return a ^ b;
        VOP_MV:  return b;
        default: return a;
    endcase
endfunction

function automatic vresult_t predict_result(input vuop_t u);
    vresult_t             r;
    vlanes_t              src1;
    vlanes_t              src2;
    vlanes_t              old;
    word_t                b;
    word_t                bits_word;
    word_t                sum;
    logic [num_lanes-1:0] active;
    logic                 hit;
    src1 = model_regs[reg_slot(u.vs1)];
    src2 = model_regs[reg_slot(u.vs2)];
    old  = model_regs[reg_slot(u.vd)];
    for (int k = 0; k < num_lanes; k++) begin
        active[k] = !u.mask_en || model_regs[0][0][k];
    end
    r.valid     = u.valid;
    r.vd        = u.vd;
    r.data      = old;
    r.lane_mask = active;
    case (u.op)
        VOP_SEQ, VOP_SLT: begin
            bits_word = '0;
            for (int k = 0; k < num_lanes; k++) begin
                b = u.use_scalar ? u.scalar : src1[k];
                if (u.op == VOP_SEQ) begin
                    hit = (src2[k] == b);
                end else begin
                    hit = ($signed(src2[k]) < $signed(b));
                end
                bits_word[k] = active[k] ? hit : old[0][k];
            end
            r.data[0]   = bits_word;
            r.lane_mask = 1;
        end
        VOP_REDSUM: begin
            sum = src1[0];
            for (int k = 0; k < num_lanes; k++) begin
                if (active[k]) begin
                    sum = sum + src2[k];
                end
            end
            r.data[0]   = sum;
            r.lane_mask = 1;
        end
        default: begin
            for (int k = 0; k < num_lanes; k++) begin
                b = u.use_scalar ? u.scalar : src1[k];
                if (active[k]) begin
                    r.data[k] = elem_op(u.op, src2[k], b);
                end
            end
        end
    endcase
    return r;
endfunction

// writeback into the register copy
function automatic void commit_result(input vresult_t r);
    if (r.valid) begin
        for (int k = 0; k < num_lanes; k++) begin
            if (r.lane_mask[k]) begin
                model_regs[reg_slot(r.vd)][k] = r.data[k];
            end
        end
    end
endfunction

`endif

//--- testbench/tb_vex_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vex_datapath;

    import vex_pkg::*;

    `include "tb_vex_model.svh"

    localparam int num_uops    = 2000;
    // 2000 micro-ops plus about 1/8 idle cycles plus reset and some margin
    localparam int cycle_limit = 2400;

    logic     CLK = 1'b0;
    logic     rst;
    vuop_t    uop;
    vresult_t result;

    vresult_t expected;
    logic     have_expected;
    int       error_count;
    int       cycle_count = 0;
    int       issued;

    vex_datapath u_vex_datapath (
        .CLK   (CLK),
        .rst   (rst),
        .uop   (uop),
        .result(result)
    );

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        error_count++;
        $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp_val, got_val);
        $display("Simulation failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    // compares the registered result with the pending expectation
    task automatic check_result();
        if (have_expected) begin
            assert (result.valid == expected.valid)
                else report_mismatch("result.valid", 32'(expected.valid), 32'(result.valid));
            if (expected.valid) begin
                assert (result.vd == expected.vd)
                    else report_mismatch("result.vd", 32'(expected.vd), 32'(result.vd));
                assert (result.lane_mask == expected.lane_mask)
                    else report_mismatch("result.lane_mask", 32'(expected.lane_mask),
                                         32'(result.lane_mask));
                for (int k = 0; k < num_lanes; k++) begin
                    assert (result.data[k] == expected.data[k])
                        else report_mismatch($sformatf("result.data[%0d]", k),
                                             expected.data[k], result.data[k]);
                end
            end
        end
    endtask

    // check the last result on the falling edge and present the next micro-op
    task automatic drive_uop(input vuop_t u);
        @(negedge CLK);
        check_result();
        uop = u;
        expected = predict_result(u);
        commit_result(expected);
        have_expected = 1'b1;
    endtask

    function automatic vuop_t make_uop(input vop_t op, input logic [2:0] vd,
                                       input logic [2:0] vs1, input logic [2:0] vs2,
                                       input logic use_scalar, input logic mask_en,
                                       input word_t scalar);
        vuop_t u;
        u.valid      = 1'b1;
        u.op         = op;
        u.vd         = 5'(vd);
        u.vs1        = 5'(vs1);
        u.vs2        = 5'(vs2);
        u.use_scalar = use_scalar;
        u.mask_en    = mask_en;
        u.scalar     = scalar;
        return u;
    endfunction

    function automatic vuop_t random_uop();
        logic [3:0] op_code;
        logic [2:0] vd;
        logic [2:0] vs1;
        logic [2:0] vs2;
        logic       use_scalar;
        logic       mask_en;
        op_code    = 4'(take_bits(4) % 9);
        vd         = 3'(take_bits(3));
        vs1        = 3'(take_bits(3));
        vs2        = 3'(take_bits(3));
        use_scalar = take_bits(1) != 0;
        mask_en    = take_bits(1) != 0;
        return make_uop(vop_t'(op_code), vd, vs1, vs2, use_scalar, mask_en, take_bits(32));
    endfunction

    initial begin
        vuop_t u;
        rst           = 1'b1;
        // a valid micro-op during reset must neither show on result nor write v2
        uop           = make_uop(VOP_MV, 3'd2, 3'd0, 3'd0, 1'b1, 1'b0, 32'hffff_ffff);
        lfsr_state    = 32'h2a5f_3818;
        error_count   = 0;
        have_expected = 1'b0;
        expected      = '0;
        for (int r = 0; r < model_vregs; r++) begin
            model_regs[r] = '0;
        end

        repeat (5) @(negedge CLK);
        assert (result.valid == 1'b0)
            else report_mismatch("result.valid", 32'h0, 32'(result.valid));
        rst = 1'b0;
        uop = '0;

        // registers are all zero straight after reset
        drive_uop(make_uop(VOP_ADD, 3'd1, 3'd2, 3'd3, 1'b0, 1'b0, '0));

        // preload twice with the second pass masked so lanes start to differ
        for (int i = 0; i < 16; i++) begin
            drive_uop(make_uop(VOP_MV, 3'(i), 3'd0, 3'd0, 1'b1, i >= 8, take_bits(32)));
        end
        issued = 17;

        while (issued < num_uops) begin
            u = random_uop();
            if (take_bits(3) == 0) begin
                // idle slot with junk fields that must not write
                u.valid = 1'b0;
            end else begin
                issued++;
            end
            drive_uop(u);
        end

        @(negedge CLK);
        check_result();

        if (error_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "errors found");
        end
    end

endmodule

`default_nettype wire
